// File: Bender.yml
package:
  name: isq

sources:
  - files:
      - rtl/isq_pkg.sv
      - rtl/isq_lin.sv
      - rtl/isq_sel.sv
      - rtl/isq_ctl.sv
      - rtl/isq_cnt.sv
      - rtl/isq_top.sv
  - target: test
    files:
      - testbench/isq_props.sv
      - testbench/isq_tb.sv

// File: project.f
rtl/isq_pkg.sv
rtl/isq_lin.sv
rtl/isq_sel.sv
rtl/isq_ctl.sv
rtl/isq_cnt.sv
rtl/isq_top.sv
testbench/isq_props.sv
testbench/isq_tb.sv

// File: rtl/isq_cnt.sv
`timescale 1ns/10ps
`default_nettype none

module isq_cnt #(
   parameter int DEPTH = 8
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       disp_take,
   input  logic                       iss_go,
   input  logic                       flush,
   input  logic [$clog2(DEPTH+1)-1:0] surv,
   input  isq_pkg::isq_inst_t         iss_inst,
   output logic [$clog2(DEPTH+1)-1:0] occ,
   output logic [$clog2(DEPTH+1)-1:0] credit_ret,
   output isq_pkg::isq_iss_t          iss
);
   import isq_pkg::*;

   localparam int CNT_W = $clog2(DEPTH+1);

   logic [CNT_W-1:0] occ_nxt;
   logic [CNT_W-1:0] ret_nxt;
   isq_iss_t         iss_nxt;

   always_comb
   begin
      if (flush)
      begin
         // dispatch in a mispredict cycle is speculative and never lands
         occ_nxt = surv;
         // issued, flushed and dropped lines all come back at once
         ret_nxt = CNT_W'(int'(occ) + int'(disp_take) - int'(surv));
      end
      else
      begin
         occ_nxt = CNT_W'(int'(occ) + int'(disp_take) - int'(iss_go));
         // one credit per issue
         ret_nxt = CNT_W'(iss_go);
      end
   end

   // bubble drives an all-zero slot
   assign iss_nxt = iss_go ? '{valid: 1'b1, inst: iss_inst} : '0;

   // occupancy and credit return
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         occ        <= '0;
         credit_ret <= '0;
      end
      else
      begin
         occ        <= occ_nxt;
         credit_ret <= ret_nxt;
      end
   end

   // issue stage register
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         iss <= '0;
      else
         iss <= iss_nxt;
   end

endmodule

`default_nettype wire

// File: rtl/isq_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module isq_ctl #(
   parameter int DEPTH = 8
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  isq_pkg::isq_disp_t         disp,
   input  logic                       found,
   input  logic                       iss_stall,
   input  logic                       brn_res_valid,
   input  logic                       brn_mispred,
   input  logic [$clog2(DEPTH+1)-1:0] occ,
   input  logic [DEPTH-1:0]           lines_brn,
   output logic                       iss_go,
   output logic                       flush,
   output logic                       clr_brn_wat,
   output logic                       spec_in,
   output logic                       disp_take,
   output logic [$clog2(DEPTH+1)-1:0] surv,
   output isq_pkg::isq_ctl_e          state
);
   import isq_pkg::*;

   localparam int CNT_W = $clog2(DEPTH+1);

   isq_ctl_e         state_nxt;
   logic             resolve;
   logic             brn_disp;
   logic [CNT_W-1:0] spec_cnt;

   ////////////////////////////////////////////////////////////////////////////
   // one-cycle commands
   ////////////////////////////////////////////////////////////////////////////

   // oldest ready line leaves unless execution holds
   assign iss_go = found & ~iss_stall;

   // resolution only means something with a branch open
   assign resolve = (state == SPEC) & brn_res_valid;
   assign flush = resolve & brn_mispred;
   assign clr_brn_wat = resolve & ~brn_mispred;

   // younger than the open branch
   assign spec_in = (state == SPEC);

   // every dispatch spends a credit, even one dropped by a flush
   assign disp_take = disp.valid;

   // a branch dropped with the flush opens nothing
   assign brn_disp = disp.valid & disp.is_brn & ~flush;

   ////////////////////////////////////////////////////////////////////////////
   // survivors of a mispredict
   ////////////////////////////////////////////////////////////////////////////

   // lines_brn is the next content of each line, incoming dispatch included
   always_comb
   begin
      spec_cnt = '0;
      for (int i = 0; i < DEPTH; i++)
      begin
         spec_cnt = spec_cnt + CNT_W'(lines_brn[i]);
      end
   end

   // lines after the edge, less the speculative tail
   // only meaningful while flush is high
   assign surv = CNT_W'(int'(occ) - int'(iss_go) + int'(disp.valid) - int'(spec_cnt));

   ////////////////////////////////////////////////////////////////////////////
   // speculation FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_nxt = state;
      case (state)
         NORMAL:
         begin
            if (brn_disp)
               state_nxt = SPEC;
         end
         SPEC:
         begin
            if (flush)
               state_nxt = FLUSH;
            // a new branch may arrive as the old one retires
            else if (clr_brn_wat)
               state_nxt = brn_disp ? SPEC : NORMAL;
         end
         FLUSH:
         begin
            // single cycle, dispatch here is already non-speculative
            state_nxt = brn_disp ? SPEC : NORMAL;
         end
         default:
         begin
            state_nxt = NORMAL;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= NORMAL;
      else
         state <= state_nxt;
   end

endmodule

`default_nettype wire

// File: rtl/isq_lin.sv
`timescale 1ns/10ps
`default_nettype none

module isq_lin (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               en,
   input  logic               clr_wat,
   input  logic               set_wat,
   input  logic               fls_inst,
   input  logic               clr_brn_wat,
   input  isq_pkg::isq_line_t lin_in,
   output isq_pkg::isq_line_t lin_out
);
   import isq_pkg::*;

   logic      wat;
   logic      brn_wat;
   isq_inst_t inst;
   logic      spec_nxt;
   logic      kill;

   // branch-wait the line carries past this edge
   assign spec_nxt = en ? lin_in.brn_wat : brn_wat;
   // flush only empties speculative content, loaded or held
   assign kill = fls_inst & spec_nxt;

   // wait bit, clear wins over set, both over load
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         wat <= 1'b0;
      else if (kill || clr_wat)
         wat <= 1'b0;
      else if (set_wat)
         wat <= 1'b1;
      else if (en)
         wat <= lin_in.wat;
   end

   // branch-wait bit, resolve clears before load
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         brn_wat <= 1'b0;
      else if (kill || clr_brn_wat)
         brn_wat <= 1'b0;
      else if (en)
         brn_wat <= lin_in.brn_wat;
   end

   // instruction word
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         inst <= '0;
      else if (kill)
         inst <= '0;
      else if (en)
         inst <= lin_in.inst;
   end

   assign lin_out = '{brn_wat: brn_wat, wat: wat, inst: inst};

endmodule

`default_nettype wire

// File: rtl/isq_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared widths, types and encodings of the issue queue
////////////////////////////////////////////////////////////////////////////
package isq_pkg;

   // instruction word width
   parameter int INST_W = 56;
   // result and source tag width
   parameter int TAG_W = 6;

   typedef logic [INST_W-1:0] isq_inst_t;
   // source tag sits in the low bits of the word
   typedef logic [TAG_W-1:0] isq_tag_t;

   // one queue line, msb first as the line register packs it
   typedef struct packed {
      // speculative behind the open branch
      logic      brn_wat;
      // source operand still pending
      logic      wat;
      isq_inst_t inst;
   } isq_line_t;

   // dispatch request
   typedef struct packed {
      logic      valid;
      isq_inst_t inst;
      // operand not yet produced
      logic      wat;
      // this instruction opens a speculation window
      logic      is_brn;
   } isq_disp_t;

   // issue slot toward execution
   typedef struct packed {
      logic      valid;
      isq_inst_t inst;
   } isq_iss_t;

   // branch speculation FSM
   typedef enum logic [1:0] {
      NORMAL = 2'd0,
      SPEC   = 2'd1,
      FLUSH  = 2'd2
   } isq_ctl_e;

endpackage

`default_nettype wire

// File: rtl/isq_sel.sv
`timescale 1ns/10ps
`default_nettype none

module isq_sel #(
   parameter int DEPTH = 8
) (
   input  isq_pkg::isq_line_t         lines [DEPTH],
   input  logic [$clog2(DEPTH+1)-1:0] occ,
   input  logic                       wake_valid,
   input  isq_pkg::isq_tag_t          wake_tag,
   input  isq_pkg::isq_disp_t         disp,
   input  logic                       spec_in,
   input  logic                       iss_go,
   output logic                       found,
   output isq_pkg::isq_inst_t         iss_inst,
   output isq_pkg::isq_line_t         lin_in [DEPTH],
   output logic [DEPTH-1:0]           en,
   output logic [DEPTH-1:0]           clr_wat
);
   import isq_pkg::*;

   localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH+1);

   logic [DEPTH-1:0] ready;
   logic [IDX_W-1:0] iss_idx;
   logic [CNT_W-1:0] disp_pos;
   isq_line_t        disp_lin;

   ////////////////////////////////////////////////////////////////////////////
   // oldest ready select
   ////////////////////////////////////////////////////////////////////////////

   // occupied, and no wait or its producer broadcasts right now
   always_comb
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         ready[i] = (i < int'(occ)) &&
                    (!lines[i].wat ||
                     (wake_valid && (lines[i].inst[TAG_W-1:0] == wake_tag)));
      end
   end

   // scan from the top, lowest index ends up winning
   always_comb
   begin
      found   = 1'b0;
      iss_idx = '0;
      for (int i = DEPTH-1; i >= 0; i--)
      begin
         if (ready[i])
         begin
            found   = 1'b1;
            iss_idx = IDX_W'(i);
         end
      end
   end

   assign iss_inst = lines[iss_idx].inst;

   ////////////////////////////////////////////////////////////////////////////
   // next content of each line
   ////////////////////////////////////////////////////////////////////////////

   // youngest slot after this cycle's issue
   assign disp_pos = occ - CNT_W'(iss_go);

   assign disp_lin = '{brn_wat: spec_in, wat: disp.wat, inst: disp.inst};

   for (genvar i = 0; i < DEPTH; i++)
   begin : g_lin
      isq_line_t up;
      logic      shift;
      logic      load;

      // top line pulls in an empty line
      if (i < DEPTH-1)
      begin : g_up
         assign up = lines[i+1];
      end
      else
      begin : g_top
         assign up = '0;
      end

      // everything at and above the issued line drops by one
      assign shift = iss_go && (i >= int'(iss_idx));
      assign load = disp.valid && (i == int'(disp_pos));
      assign en[i] = shift | load;
      // hold keeps own content so the bus always shows the next value
      assign lin_in[i] = load ? disp_lin : (shift ? up : lines[i]);
      // wakeup follows the word the line ends up with, dispatch included
      assign clr_wat[i] = wake_valid && (lin_in[i].inst[TAG_W-1:0] == wake_tag);
   end

endmodule

`default_nettype wire

// File: rtl/isq_top.sv
`timescale 1ns/10ps
`default_nettype none

module isq_top #(
   parameter int DEPTH = 8
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  isq_pkg::isq_disp_t         disp,
   input  logic                       wake_valid,
   input  isq_pkg::isq_tag_t          wake_tag,
   input  logic                       brn_res_valid,
   input  logic                       brn_mispred,
   input  logic                       iss_stall,
   output isq_pkg::isq_iss_t          iss,
   output logic [$clog2(DEPTH+1)-1:0] credit_ret
);
   import isq_pkg::*;

   localparam int CNT_W = $clog2(DEPTH+1);

   isq_line_t        lines [DEPTH];
   isq_line_t        lin_in [DEPTH];
   logic [DEPTH-1:0] en;
   logic [DEPTH-1:0] clr_wat;
   logic [DEPTH-1:0] lines_brn;
   logic [CNT_W-1:0] occ;
   logic [CNT_W-1:0] surv;
   isq_inst_t        iss_inst;
   logic             found;
   logic             iss_go;
   logic             flush;
   logic             clr_brn_wat;
   logic             spec_in;
   logic             disp_take;

   // queue lines, position 0 is the oldest
   for (genvar i = 0; i < DEPTH; i++)
   begin : g_line
      isq_lin isq_lin_i (
         .clk         (clk),
         .rst_n       (rst_n),
         .en          (en[i]),
         .clr_wat     (clr_wat[i]),
         // no replay path sets a wait bit again
         .set_wat     (1'b0),
         .fls_inst    (flush),
         .clr_brn_wat (clr_brn_wat),
         .lin_in      (lin_in[i]),
         .lin_out     (lines[i])
      );

      // speculative marks as they will be loaded
      assign lines_brn[i] = lin_in[i].brn_wat;
   end

   isq_sel #(.DEPTH(DEPTH)) isq_sel_i (
      .lines      (lines),
      .occ        (occ),
      .wake_valid (wake_valid),
      .wake_tag   (wake_tag),
      .disp       (disp),
      .spec_in    (spec_in),
      .iss_go     (iss_go),
      .found      (found),
      .iss_inst   (iss_inst),
      .lin_in     (lin_in),
      .en         (en),
      .clr_wat    (clr_wat)
   );

   isq_ctl #(.DEPTH(DEPTH)) isq_ctl_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .disp          (disp),
      .found         (found),
      .iss_stall     (iss_stall),
      .brn_res_valid (brn_res_valid),
      .brn_mispred   (brn_mispred),
      .occ           (occ),
      .lines_brn     (lines_brn),
      .iss_go        (iss_go),
      .flush         (flush),
      .clr_brn_wat   (clr_brn_wat),
      .spec_in       (spec_in),
      .disp_take     (disp_take),
      .surv          (surv),
      // state only observed inside the control block
      .state         ()
   );

   isq_cnt #(.DEPTH(DEPTH)) isq_cnt_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .disp_take  (disp_take),
      .iss_go     (iss_go),
      .flush      (flush),
      .surv       (surv),
      .iss_inst   (iss_inst),
      .occ        (occ),
      .credit_ret (credit_ret),
      .iss        (iss)
   );

endmodule

`default_nettype wire

// File: testbench/isq_props.sv
`timescale 1ns/10ps
`default_nettype none

module isq_props #(
   parameter int DEPTH = 8,
   // credit side sits on isq_cnt, branch side on isq_ctl
   parameter bit CNT_SIDE = 1'b0
) (
   input logic                       clk,
   input logic                       rst_n,
   input logic                       flush,
   input logic [$clog2(DEPTH+1)-1:0] occ,
   input logic [$clog2(DEPTH+1)-1:0] ret,
   input logic [DEPTH-1:0]           lines_brn,
   input logic                       spec,
   input logic                       brn_new
);

   // assertion failures so far
   int fail_cnt = 0;

   if (CNT_SIDE)
   begin : g_credit

      /////////////////////////////////////////////////////////////////////////
      // credit bounds
      /////////////////////////////////////////////////////////////////////////

      occ_bound_a : assert property (@(posedge clk) disable iff (!rst_n) int'(occ) <= DEPTH)
      else
      begin
         fail_cnt++;
         $error("occupancy %0d above depth", occ);
      end

      // one cycle never returns more than the whole queue
      ret_bound_a : assert property (@(posedge clk) disable iff (!rst_n) int'(ret) <= DEPTH)
      else
      begin
         fail_cnt++;
         $error("credit return %0d above depth", ret);
      end

   end
   else
   begin : g_branch

      /////////////////////////////////////////////////////////////////////////
      // branch and flush
      /////////////////////////////////////////////////////////////////////////

      // second branch only alongside the resolution of the first
      one_brn_a : assert property (@(posedge clk) disable iff (!rst_n) spec |-> !brn_new)
      else
      begin
         fail_cnt++;
         $error("branch dispatched while another is open");
      end

      // no speculative mark survives a mispredict
      flush_clears_a : assert property (
         @(posedge clk) disable iff (!rst_n) flush |=> lines_brn == '0
      )
      else
      begin
         fail_cnt++;
         $error("speculative lines %b left after flush", lines_brn);
      end

      // dispatch is dropped with the flush, so the queue cannot grow
      flush_shrink_a : assert property (
         @(posedge clk) disable iff (!rst_n) flush |=> int'(occ) <= int'($past(occ))
      )
      else
      begin
         fail_cnt++;
         $error("occupancy %0d after flush, was %0d", occ, $past(occ));
      end

   end

endmodule

bind isq_ctl isq_props #(.DEPTH(DEPTH), .CNT_SIDE(1'b0)) ctl_props_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .flush     (flush),
   .occ       (occ),
   .ret       ('0),
   .lines_brn (lines_brn),
   .spec      (state == isq_pkg::SPEC),
   .brn_new   (disp.valid && disp.is_brn && !brn_res_valid)
);

bind isq_cnt isq_props #(.DEPTH(DEPTH), .CNT_SIDE(1'b1)) cnt_props_i (
   .clk       (clk),
   .rst_n     (rst_n),
   .flush     (flush),
   .occ       (occ),
   .ret       (credit_ret),
   .lines_brn ('0),
   .spec      (1'b0),
   .brn_new   (1'b0)
);

`default_nettype wire

// File: testbench/isq_tb.sv
`timescale 1ns/10ps
`default_nettype none

module isq_tb;
   import isq_pkg::*;

   localparam int DEPTH = 8;
   localparam int CNT_W = $clog2(DEPTH+1);
   // tags in use, kept small so wakeups hit often
   localparam int NTAGS = 8;
   localparam int CLK_NS = 4;

   // phase lengths in cycles
   localparam int RESET_CYC = 3;
   localparam int IDLE_CYC = 10;
   localparam int ORDER_CYC = 200;
   localparam int WAKE_CYC = 300;
   localparam int STALL_CYC = 300;
   localparam int RESOLVE_CYC = 300;
   localparam int MISP_CYC = 300;
   localparam int MIX_CYC = 2000;
   localparam int DRAIN_MAX = 64;
   localparam int NUM_DRAINS = 6;
   localparam int TOTAL_CYC = RESET_CYC + IDLE_CYC + ORDER_CYC + WAKE_CYC + STALL_CYC +
                              RESOLVE_CYC + MISP_CYC + MIX_CYC + NUM_DRAINS * DRAIN_MAX;
   localparam int WATCHDOG_NS = TOTAL_CYC * CLK_NS + 400;

   typedef logic [CNT_W-1:0] cnt_t;

   logic      clk;
   logic      rst_n;
   isq_disp_t disp;
   logic      wake_valid;
   isq_tag_t  wake_tag;
   logic      brn_res_valid;
   logic      brn_mispred;
   logic      iss_stall;
   isq_iss_t  iss;
   cnt_t      credit_ret;

   // reference queue, index 0 oldest
   isq_line_t m_q [DEPTH];
   int        m_occ;
   isq_ctl_e  m_state;
   isq_iss_t  exp_iss;
   cnt_t      exp_credit;

   // dispatcher side
   int        credits;
   bit        brn_open;
   int        seq;

   isq_top #(.DEPTH(DEPTH)) isq_top_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .disp          (disp),
      .wake_valid    (wake_valid),
      .wake_tag      (wake_tag),
      .brn_res_valid (brn_res_valid),
      .brn_mispred   (brn_mispred),
      .iss_stall     (iss_stall),
      .iss           (iss),
      .credit_ret    (credit_ret)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_NS/2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // source tag sits in the low bits of the word
   function automatic bit tag_hit(input isq_line_t l, input logic wv, input isq_tag_t wt);
      return wv && (l.inst[TAG_W-1:0] == wt);
   endfunction

   task automatic model_reset();
      for (int i = 0; i < DEPTH; i++)
         m_q[i] = '0;
      m_occ = 0;
      m_state = NORMAL;
      exp_iss = '0;
      exp_credit = '0;
   endtask

   // one clock edge of the queue, returns 0 on overflow
   function automatic bit model_step(
      input isq_disp_t d,
      input logic      wv,
      input isq_tag_t  wt,
      input logic      res_v,
      input logic      misp,
      input logic      stall
   );
      isq_line_t nq [DEPTH+1];
      int        n;
      int        keep;
      int        idx;
      int        i;
      bit        fnd;
      bit        go;
      bit        spec;
      bit        fls;
      bit        clr;
      bit        brn_new;
      fnd = 1'b0;
      idx = 0;
      // oldest ready, a tag broadcast this cycle counts
      for (i = 0; i < m_occ; i++)
      begin
         if (!fnd && (!m_q[i].wat || tag_hit(m_q[i], wv, wt)))
         begin
            fnd = 1'b1;
            idx = i;
         end
      end
      go = fnd && !stall;
      spec = (m_state == SPEC);
      fls = spec && res_v && misp;
      clr = spec && res_v && !misp;
      exp_iss = go ? '{valid: 1'b1, inst: m_q[idx].inst} : '0;
      // issued line leaves, the rest close the gap
      n = 0;
      for (i = 0; i < m_occ; i++)
      begin
         if (!(go && i == idx))
         begin
            nq[n] = m_q[i];
            n++;
         end
      end
      // youngest slot takes the dispatch
      if (d.valid)
      begin
         if (n >= DEPTH)
            return 1'b0;
         nq[n] = '{brn_wat: spec, wat: d.wat, inst: d.inst};
         n++;
      end
      for (i = 0; i < n; i++)
      begin
         if (tag_hit(nq[i], wv, wt))
            nq[i].wat = 1'b0;
         if (clr)
            nq[i].brn_wat = 1'b0;
      end
      // mispredict keeps only non-speculative lines
      keep = 0;
      for (i = 0; i < n; i++)
      begin
         if (!(fls && nq[i].brn_wat))
         begin
            m_q[keep] = nq[i];
            keep++;
         end
      end
      for (i = keep; i < DEPTH; i++)
         m_q[i] = '0;
      exp_credit = cnt_t'(int'(go) + (n - keep));
      m_occ = keep;
      brn_new = d.valid && d.is_brn && !fls;
      case (m_state)
         NORMAL:
         begin
            if (brn_new)
               m_state = SPEC;
         end
         SPEC:
         begin
            if (fls)
               m_state = FLUSH;
            else if (clr)
               m_state = brn_new ? SPEC : NORMAL;
         end
         default:
         begin
            m_state = brn_new ? SPEC : NORMAL;
         end
      endcase
      return 1'b1;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // compare
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_iss(input string name, input isq_iss_t got, input isq_iss_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "%s compare failed", name);
      end
   endtask

   task automatic check_credit(input string name, input cnt_t got, input cnt_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "%s compare failed", name);
      end
   endtask

   // inputs settle on the falling edge, outputs a step after the rising one
   initial
   begin : compare_outputs
      wait (rst_n === 1'b1);
      check_iss("iss", iss, isq_iss_t'(0));
      check_credit("credit_ret", credit_ret, cnt_t'(0));
      forever
      begin
         @(posedge clk);
         if (!model_step(disp, wake_valid, wake_tag, brn_res_valid, brn_mispred, iss_stall))
         begin
            $display("dispatch at %0t into a full queue, dispatcher overspent", $time);
            $display("TEST FAILED");
            $fatal(1, "queue overflow");
         end
         #1;
         check_iss("iss", iss, exp_iss);
         check_credit("credit_ret", credit_ret, exp_credit);
         if (assertion_failures() != 0)
         begin
            $display("bound assertion failed by %0t, see the error above", $time);
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   function automatic bit chance(input int pct);
      return ($urandom % 100) < pct;
   endfunction

   // sequence number above the tag, so each word is unique
   function automatic isq_inst_t make_inst();
      isq_inst_t inst;
      seq++;
      inst = isq_inst_t'(seq);
      inst = (inst << TAG_W) | isq_inst_t'($urandom % NTAGS);
      return inst;
   endfunction

   task automatic run_phase(input int cycles, input int p_disp, input int p_wait,
                            input int p_wake, input int p_stall, input int p_brn,
                            input int p_res, input int p_misp);
      isq_disp_t d;
      int        c;
      for (c = 0; c < cycles; c++)
      begin
         @(negedge clk);
         credits = credits + int'(credit_ret);
         d = '0;
         brn_res_valid = 1'b0;
         brn_mispred = 1'b0;
         if (brn_open && chance(p_res))
         begin
            brn_res_valid = 1'b1;
            brn_mispred = chance(p_misp);
            brn_open = 1'b0;
         end
         if (credits > 0 && chance(p_disp))
         begin
            d.valid = 1'b1;
            d.inst = make_inst();
            d.wat = chance(p_wait);
            // no new branch while one is open or resolving
            if (!brn_open && !brn_res_valid && chance(p_brn))
            begin
               d.is_brn = 1'b1;
               brn_open = 1'b1;
            end
            credits--;
         end
         disp = d;
         wake_valid = chance(p_wake);
         wake_tag = isq_tag_t'($urandom % NTAGS);
         iss_stall = chance(p_stall);
      end
   endtask

   // wake every tag in turn until the reference queue is empty
   task automatic drain_queue();
      int cyc;
      bit done;
      cyc = 0;
      done = 1'b0;
      while (!done && cyc < DRAIN_MAX)
      begin
         @(negedge clk);
         credits = credits + int'(credit_ret);
         done = (m_occ == 0) && !brn_open;
         disp = '0;
         iss_stall = 1'b0;
         wake_valid = !done;
         wake_tag = isq_tag_t'(cyc % NTAGS);
         brn_res_valid = brn_open;
         brn_mispred = 1'b0;
         brn_open = 1'b0;
         cyc++;
      end
      if (!done)
      begin
         $display("queue did not drain in %0d cycles, %0d credits back", DRAIN_MAX, credits);
         $display("TEST FAILED");
         $fatal(1, "drain incomplete");
      end
      // every credit is back once the queue is empty
      check_credit("dispatcher credits", cnt_t'(credits), cnt_t'(DEPTH));
   endtask

   function automatic int assertion_failures();
      return isq_top_i.isq_ctl_i.ctl_props_i.fail_cnt +
             isq_top_i.isq_cnt_i.cnt_props_i.fail_cnt;
   endfunction

   initial
   begin
      void'($urandom(32'h316c));
      rst_n = 1'b0;
      disp = '0;
      wake_valid = 1'b0;
      wake_tag = '0;
      brn_res_valid = 1'b0;
      brn_mispred = 1'b0;
      iss_stall = 1'b0;
      credits = DEPTH;
      brn_open = 1'b0;
      seq = 0;
      model_reset();
      repeat (RESET_CYC) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // quiet queue after reset
      run_phase(IDLE_CYC, 0, 0, 0, 0, 0, 0, 0);
      // ready only, age order
      run_phase(ORDER_CYC, 60, 0, 0, 0, 0, 0, 0);
      drain_queue();
      // waiting lines and bypass
      run_phase(WAKE_CYC, 70, 50, 40, 0, 0, 0, 0);
      drain_queue();
      run_phase(STALL_CYC, 70, 30, 40, 40, 0, 0, 0);
      drain_queue();
      // correct predictions only
      run_phase(RESOLVE_CYC, 70, 30, 40, 20, 15, 20, 0);
      drain_queue();
      // every resolution mispredicts
      run_phase(MISP_CYC, 70, 30, 40, 20, 15, 20, 100);
      drain_queue();
      run_phase(MIX_CYC, 65, 35, 40, 25, 10, 15, 50);
      drain_queue();
      @(negedge clk);
      if (assertion_failures() == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   initial
   begin : watchdog
      #(WATCHDOG_NS);
      $display("run still going after %0t, watchdog expired", $time);
      $display("TEST FAILED");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire
